// ==== Bender.yml ====
package:
  name: mmu_xlate

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mmuWalkPkg.sv
      - rtl/mmuFaultPkg.sv
      - rtl/tableWalker.sv
      - rtl/walkAddrGen.sv
      - rtl/tlbArray.sv
      - rtl/faultRegs.sv
      - rtl/mmuTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/mmuTb.sv

// ==== compile.f ====
+incdir+rtl
rtl/mmuWalkPkg.sv
rtl/mmuFaultPkg.sv
rtl/tableWalker.sv
rtl/walkAddrGen.sv
rtl/tlbArray.sv
rtl/faultRegs.sv
rtl/mmuTop.sv
dv/mmuTb.sv

// ==== dv/mmuTb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mmu_params.svh"

module mmuTb
  import mmuWalkPkg::*;
  import mmuFaultPkg::*;
();

  localparam int NUM_ITER    = 80;
  localparam int NUM_REGIONS = 6;
  // Up to four requests per iteration, 40 cycles each
  localparam int WATCHDOG_CYCLES = NUM_ITER * 4 * 40 + 100;
  localparam logic [31:0] SEED = 32'h5f5d_d1c8;
  // First-level table at 0x40000
  localparam logic [`TBASE_W-1:0] TABLE_BASE = 18'h00010;
  // Second-level tables live here, one 4 KB slot per first-level index
  localparam logic [31:0] L2_AREA = 32'h1000_0000;

  logic                 clk;
  logic                 reset;
  logic                 requestPA;
  logic [`VADDR_W-1:0]  virtAdr;
  logic                 dataAccess;
  logic                 mmuEnable;
  logic [`TBASE_W-1:0]  tBase;
  logic                 tlbFlush;
  logic                 paReady;
  logic [`PADDR_W-1:0]  physAdr;
  logic                 abort;
  logic                 memRequest;
  logic [`PADDR_W-1:0]  memAddr;
  logic                 memReady;
  logic [`DATA_W-1:0]   memRData;
  logic [`FSR_W-1:0]    faultStatusReg;
  logic [`VADDR_W-1:0]  faultAddrReg;

  // Sparse page-table memory, word addressed by byte address
  logic [31:0] pageMem [logic [31:0]];
  logic [11:0] regionIdx [NUM_REGIONS];
  logic [31:0] stimRng;
  logic [31:0] waitRng;
  int unsigned waitLeft;
  int          errorCount;
  int          checkCount;
  int          requestCount;

  mmuTop UUT (
    .clk            (clk),
    .reset          (reset),
    .requestPA      (requestPA),
    .virtAdr        (virtAdr),
    .dataAccess     (dataAccess),
    .mmuEnable      (mmuEnable),
    .tBase          (tBase),
    .tlbFlush       (tlbFlush),
    .paReady        (paReady),
    .physAdr        (physAdr),
    .abort          (abort),
    .memRequest     (memRequest),
    .memAddr        (memAddr),
    .memReady       (memReady),
    .memRData       (memRData),
    .faultStatusReg (faultStatusReg),
    .faultAddrReg   (faultAddrReg)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================
  // Random numbers
  // ====================
  function automatic logic [31:0] lcgStep(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] nextRand();
    stimRng = lcgStep(stimRng);
    return stimRng;
  endfunction

  // Upper bits only, low LCG bits cycle fast
  function automatic int unsigned randBelow(input int unsigned n);
    logic [31:0] r;
    r = nextRand();
    return r[31:16] % n;
  endfunction

  // ====================
  // Page-table memory model
  // ====================
  function automatic logic [31:0] readMem(input logic [31:0] addr);
    if (pageMem.exists(addr)) begin
      return pageMem[addr];
    end
    return 32'h0;
  endfunction

  // Descriptor address for walk level 0 or 1
  function automatic logic [31:0] descAddr(input logic [31:0] va, input int unsigned level);
    logic [31:0] fl;
    fl = readMem({TABLE_BASE, va[31:20], 2'b00});
    if (level == 0) begin
      return {TABLE_BASE, va[31:20], 2'b00};
    end else if (fl[1:0] == 2'b01) begin
      return {fl[31:10], va[19:12], 2'b00};
    end
    return {fl[31:12], va[19:10], 2'b00};
  endfunction

  // Coarse table, 256 entries; large pages replicated over 16
  task automatic fillCoarse(input logic [31:0] base);
    logic [31:0] rnd;
    logic [31:0] desc;
    for (int g = 0; g < 16; g++) begin
      rnd = nextRand();
      desc = {nextRand() & 32'hFFFF_0000};
      desc[1:0] = 2'b01;
      for (int e = 0; e < 16; e++) begin
        if (rnd[17:16] != 2'b00) begin
          // Small page, or a fault now and then
          desc = nextRand();
          desc[1:0] = (desc[17:16] == 2'b00) ? 2'b00 : 2'b10;
          if (desc[1:0] == 2'b10) begin
            desc[11:2] = '0;
          end
        end
        pageMem[base + 32'((g * 16 + e) * 4)] = desc;
      end
    end
  endtask

  // Fine table, 1024 entries; small pages replicated over 4
  task automatic fillFine(input logic [31:0] base);
    int unsigned kind;
    logic [31:0] desc;
    for (int g = 0; g < 256; g++) begin
      kind = randBelow(3);
      desc = {nextRand() & 32'hFFFF_F000};
      desc[1:0] = 2'b10;
      for (int e = 0; e < 4; e++) begin
        if (kind == 1) begin
          desc = {nextRand() & 32'hFFFF_FC00};
          desc[1:0] = 2'b11;
        end else if (kind == 2) begin
          desc = {nextRand() & 32'hFFFF_FFFC};
        end
        pageMem[base + 32'((g * 4 + e) * 4)] = desc;
      end
    end
  endtask

  // First-level entries for a few regions, first four cover every kind
  task automatic buildTables();
    logic [31:0] rnd;
    logic [31:0] desc;
    logic [31:0] l2Base;
    logic [3:0]  domain;
    int unsigned kind;
    for (int r = 0; r < NUM_REGIONS; r++) begin
      rnd = nextRand();
      regionIdx[r] = {r[2:0], rnd[8:0]};
      domain = rnd[15:12];
      l2Base = L2_AREA | (32'(regionIdx[r]) << 12);
      kind = (r < 4) ? r : randBelow(4);
      case (kind)
        0: desc = {rnd[31:20], 11'b0, domain, 3'b0, 2'b10};
        1: begin
          desc = {l2Base[31:10], 1'b0, domain, 3'b0, 2'b01};
          fillCoarse(l2Base);
        end
        2: begin
          desc = {l2Base[31:12], 3'b0, domain, 3'b0, 2'b11};
          fillFine(l2Base);
        end
        default: desc = {rnd[31:9], domain, 3'b0, 2'b00};
      endcase
      pageMem[{TABLE_BASE, regionIdx[r], 2'b00}] = desc;
    end
  endtask

  // Read port, 0 to 3 wait cycles per access
  always @(negedge clk) begin
    if (reset) begin
      memReady <= 1'b0;
      waitLeft <= 0;
    end else if (memReady) begin
      memReady <= 1'b0;
      waitRng = lcgStep(waitRng);
      waitLeft <= waitRng[31:16] % 4;
    end else if (memRequest) begin
      if (waitLeft == 0) begin
        memReady <= 1'b1;
        memRData <= readMem(memAddr);
      end else begin
        waitLeft <= waitLeft - 1;
      end
    end
  end

  // ====================
  // Reference translator
  // ====================
  task automatic referenceWalk(input logic [31:0] va, output logic isFault,
                               output logic [31:0] pa, output pageSize size,
                               output faultStatus status, output logic [3:0] domain);
    logic [31:0] fl;
    logic [31:0] sl;
    fl = readMem({TABLE_BASE, va[31:20], 2'b00});
    sl = '0;
    domain = fl[8:5];
    isFault = 1'b0;
    status = NOFAULT;
    size = SECTION;
    pa = '0;
    case (firstLevelKind'(fl[1:0]))
      FLFAULT: begin
        isFault = 1'b1;
        status = SECTIONXLATE;
      end
      FLSECTION: pa = {fl[31:20], va[19:0]};
      FLCOARSE:  sl = readMem({fl[31:10], va[19:12], 2'b00});
      default:   sl = readMem({fl[31:12], va[19:10], 2'b00});
    endcase
    // Second level only behind a table descriptor
    if (fl[0]) begin
      case (secondLevelKind'(sl[1:0]))
        SLFAULT: begin
          isFault = 1'b1;
          status = PAGEXLATE;
        end
        SLLARGE: begin
          size = LARGE;
          pa = {sl[31:16], va[15:0]};
        end
        SLSMALL: begin
          size = SMALL;
          pa = {sl[31:12], va[11:0]};
        end
        default: begin
          size = TINY;
          pa = {sl[31:10], va[9:0]};
        end
      endcase
    end
  endtask

  function automatic logic [31:0] pageMask(input pageSize size);
    case (size)
      SECTION: return 32'h000F_FFFF;
      LARGE:   return 32'h0000_FFFF;
      SMALL:   return 32'h0000_0FFF;
      default: return 32'h0000_03FF;
    endcase
  endfunction

  // ====================
  // Checks
  // ====================
  task automatic reportError(input string msg);
    errorCount++;
    $display("[ERROR] %0t %s", $time, msg);
  endtask

  task automatic checkAddr(input string name, input logic [`PADDR_W-1:0] got, exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkFar(input string name, input logic [`VADDR_W-1:0] got, exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Status, domain and data flag of the FSR
  task automatic checkFault(input string name, input faultStatus gotStatus, expStatus,
                            input logic [3:0] gotDomain, expDomain,
                            input logic gotData, expData);
    checkCount++;
    if (gotStatus !== expStatus || gotDomain !== expDomain || gotData !== expData) begin
      errorCount++;
      $display("[FAIL] %0t %s got %s/%h/%b expected %s/%h/%b", $time, name,
               gotStatus.name(), gotDomain, gotData, expStatus.name(), expDomain, expData);
    end
  endtask

  task automatic checkState(input string name, input walkState got, exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[FAIL] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic checkFlag(input string name, input logic got, exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // ====================
  // Requester
  // ====================
  // Hold the request until paReady or abort, sampled before each edge
  task automatic runRequest(input logic [31:0] va, input logic da, input logic enable,
                            output logic gotAbort, output logic [31:0] gotPa,
                            output logic sawMem);
    logic        done;
    int unsigned level;
    @(negedge clk);
    virtAdr = va;
    dataAccess = da;
    mmuEnable = enable;
    requestPA = 1'b1;
    done = 1'b0;
    sawMem = 1'b0;
    gotAbort = 1'b0;
    gotPa = '0;
    level = 0;
    while (!done) begin
      @(posedge clk);
      if (memRequest) begin
        sawMem = 1'b1;
      end
      // Each accepted fetch uses the table address of its level
      if (memRequest && memReady) begin
        checkAddr("memAddr", memAddr, descAddr(va, level));
        level++;
      end
      if (paReady) begin
        gotPa = physAdr;
        done = 1'b1;
      end else if (abort) begin
        gotAbort = 1'b1;
        done = 1'b1;
      end
    end
    // One idle cycle before the next request
    @(negedge clk);
    requestPA = 1'b0;
    mmuEnable = 1'b1;
    requestCount++;
  endtask

  task automatic flushTlb();
    @(negedge clk);
    tlbFlush = 1'b1;
    @(negedge clk);
    tlbFlush = 1'b0;
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    logic [31:0] rnd;
    logic [31:0] va;
    logic [31:0] va2;
    logic [31:0] mask;
    logic        da;
    logic        expFault;
    logic [31:0] expPa;
    pageSize     expSize;
    faultStatus  expStatus;
    logic [3:0]  expDomain;
    logic        gotAbort;
    logic [31:0] gotPa;
    logic        sawMem;

    reset = 1'b1;
    requestPA = 1'b0;
    virtAdr = '0;
    dataAccess = 1'b0;
    mmuEnable = 1'b1;
    tBase = TABLE_BASE;
    tlbFlush = 1'b0;
    memReady = 1'b0;
    memRData = '0;
    errorCount = 0;
    checkCount = 0;
    requestCount = 0;
    stimRng = SEED;
    waitRng = SEED;
    buildTables();

    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Idle after reset
    checkFlag("paReady", paReady, 1'b0);
    checkFlag("abort", abort, 1'b0);
    checkFlag("memRequest", memRequest, 1'b0);
    checkFault("faultStatusReg", faultStatus'(faultStatusReg[3:0]), NOFAULT,
               faultStatusReg[7:4], 4'h0, faultStatusReg[8], 1'b0);
    checkFar("faultAddrReg", faultAddrReg, 32'h0);
    checkState("state", UUT.state, READY);

    for (int n = 0; n < NUM_ITER; n++) begin
      rnd = nextRand();
      va = {regionIdx[randBelow(NUM_REGIONS)], rnd[19:0]};
      da = rnd[24];
      if (n % 8 == 7) begin
        // MMU off, address goes straight through
        runRequest(va, da, 1'b0, gotAbort, gotPa, sawMem);
        if (gotAbort) begin
          reportError($sformatf("abort with the MMU disabled for %h", va));
        end
        checkAddr("physAdr", gotPa, va);
        checkFlag("memRequest", sawMem, 1'b0);
      end else begin
        referenceWalk(va, expFault, expPa, expSize, expStatus, expDomain);
        runRequest(va, da, 1'b1, gotAbort, gotPa, sawMem);
        if (expFault) begin
          if (!gotAbort) begin
            reportError($sformatf("no abort for faulting address %h", va));
          end
          checkFault("faultStatusReg", faultStatus'(faultStatusReg[3:0]), expStatus,
                     faultStatusReg[7:4], expDomain, faultStatusReg[8], da);
          checkFar("faultAddrReg", faultAddrReg, va);
        end else if (gotAbort) begin
          reportError($sformatf("unexpected abort for address %h", va));
        end else begin
          checkAddr("physAdr", gotPa, expPa);
          // Another offset in the same page must hit
          rnd = nextRand();
          mask = pageMask(expSize);
          va2 = (va & ~mask) | (rnd & mask);
          runRequest(va2, da, 1'b1, gotAbort, gotPa, sawMem);
          checkAddr("physAdr", gotPa, (expPa & ~mask) | (rnd & mask));
          checkFlag("memRequest", sawMem, 1'b0);
          if (n % 4 == 0) begin
            // Emptied TLB walks again
            flushTlb();
            runRequest(va, da, 1'b1, gotAbort, gotPa, sawMem);
            checkAddr("physAdr", gotPa, expPa);
            checkFlag("memRequest", sawMem, 1'b1);
          end
        end
      end
    end

    checkState("state", UUT.state, READY);
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the request count
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, %0d requests done",
             WATCHDOG_CYCLES, requestCount);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/faultRegs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mmu_params.svh"

module faultRegs
  import mmuFaultPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fsrWrite,
  input  logic                  farWrite,
  input  faultStatus            faultCode,
  input  logic [`DOMAIN_W-1:0]  faultDomain,
  input  logic                  dataAccess,
  input  logic [`VADDR_W-1:0]   virtAdr,
  output logic [`FSR_W-1:0]     faultStatusReg,
  output logic [`VADDR_W-1:0]   faultAddrReg
);

  fsrFields            fsrState;
  fsrFields            fsrNext;
  logic [`VADDR_W-1:0] farState;

  // Status word for the current fault
  assign fsrNext = '{dataFlag: dataAccess, domain: faultDomain, status: faultCode};

  // ====================
  // FSR and FAR
  // ====================
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      fsrState <= '0;
      farState <= '0;
    end else begin
      if (fsrWrite) begin
        fsrState <= fsrNext;
      end
      if (farWrite) begin
        farState <= virtAdr;
      end
    end
  end

  assign faultStatusReg = fsrState;
  assign faultAddrReg   = farState;

  // Walker only records real faults
  assert property (@(posedge clk) disable iff (reset) fsrWrite |-> faultCode != NOFAULT);

  // FAR lands the cycle after the FSR
  assert property (@(posedge clk) disable iff (reset) fsrWrite |=> farWrite);

endmodule

`default_nettype wire

// ==== rtl/mmuFaultPkg.sv ====
`default_nettype none
`include "mmu_params.svh"

package mmuFaultPkg;

  // Status codes for translation faults
  typedef enum logic [3:0] {
    NOFAULT      = 4'b0000,
    SECTIONXLATE = 4'b0101,
    PAGEXLATE    = 4'b0111
  } faultStatus;

  // FSR layout, data flag on top
  typedef struct packed {
    logic                   dataFlag;
    logic [`DOMAIN_W-1:0]   domain;
    faultStatus             status;
  } fsrFields;

endpackage

`default_nettype wire

// ==== rtl/mmuTop.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mmu_params.svh"

module mmuTop
  import mmuWalkPkg::*;
  import mmuFaultPkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  // Requester
  input  logic                 requestPA,
  input  logic [`VADDR_W-1:0]  virtAdr,
  input  logic                 dataAccess,
  input  logic                 mmuEnable,
  input  logic [`TBASE_W-1:0]  tBase,
  input  logic                 tlbFlush,
  output logic                 paReady,
  output logic [`PADDR_W-1:0]  physAdr,
  output logic                 abort,
  // Memory read port
  output logic                 memRequest,
  output logic [`PADDR_W-1:0]  memAddr,
  input  logic                 memReady,
  input  logic [`DATA_W-1:0]   memRData,
  // Fault registers
  output logic [`FSR_W-1:0]    faultStatusReg,
  output logic [`VADDR_W-1:0]  faultAddrReg
);

  walkState             state;
  faultStatus           faultCode;
  pageSize              fillSize;
  logic                 tlbHit;
  logic                 tlbWrite;
  logic                 fsrWrite;
  logic                 farWrite;
  logic [`VADDR_W-1:0]  fillVirt;
  logic [`PADDR_W-1:0]  fillPhys;
  logic [`DOMAIN_W-1:0] faultDomain;

  // ====================
  // Walker FSM
  // ====================
  tableWalker walker (
    .clk        (clk),
    .reset      (reset),
    .requestPA  (requestPA),
    .dataAccess (dataAccess),
    .mmuEnable  (mmuEnable),
    .tlbHit     (tlbHit),
    .memReady   (memReady),
    .memRData   (memRData),
    .memRequest (memRequest),
    .tlbWrite   (tlbWrite),
    .fsrWrite   (fsrWrite),
    .farWrite   (farWrite),
    .paReady    (paReady),
    .abort      (abort),
    .faultCode  (faultCode),
    .state      (state)
  );

  // Fetch addresses and fill fields
  walkAddrGen addrGen (
    .clk         (clk),
    .reset       (reset),
    .state       (state),
    .memReady    (memReady),
    .memRData    (memRData),
    .virtAdr     (virtAdr),
    .tBase       (tBase),
    .memAddr     (memAddr),
    .fillVirt    (fillVirt),
    .fillPhys    (fillPhys),
    .fillSize    (fillSize),
    .faultDomain (faultDomain)
  );

  // Translation and bypass path
  tlbArray tlb (
    .clk        (clk),
    .reset      (reset),
    .flush      (tlbFlush),
    .enable     (mmuEnable),
    .lookupVirt (virtAdr),
    .hit        (tlbHit),
    .hitPhys    (physAdr),
    .write      (tlbWrite),
    .fillVirt   (fillVirt),
    .fillPhys   (fillPhys),
    .fillSize   (fillSize)
  );

  faultRegs faults (
    .clk            (clk),
    .reset          (reset),
    .fsrWrite       (fsrWrite),
    .farWrite       (farWrite),
    .faultCode      (faultCode),
    .faultDomain    (faultDomain),
    .dataAccess     (dataAccess),
    .virtAdr        (virtAdr),
    .faultStatusReg (faultStatusReg),
    .faultAddrReg   (faultAddrReg)
  );

endmodule

`default_nettype wire

// ==== rtl/mmuWalkPkg.sv ====
`default_nettype none

package mmuWalkPkg;

  // Walker FSM states
  typedef enum logic [2:0] {
    READY,
    FLD,
    COARSEFETCH,
    FINEFETCH,
    COARSED,
    FINED,
    FAULTFSR,
    FAULTFAR
  } walkState;

  // Mapping granularity held per TLB entry
  typedef enum logic [1:0] {SECTION, LARGE, SMALL, TINY} pageSize;

  // Descriptor bits 1:0 at each level
  typedef enum logic [1:0] {FLFAULT, FLCOARSE, FLSECTION, FLFINE} firstLevelKind;
  typedef enum logic [1:0] {SLFAULT, SLLARGE, SLSMALL, SLTINY} secondLevelKind;

endpackage

`default_nettype wire

// ==== rtl/mmu_params.svh ====
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// Address widths
`define VADDR_W 32
`define PADDR_W 32
// Descriptor and memory read data
`define DATA_W 32

// First-level table base, 16 KB aligned
`define TBASE_W 18
// Domain field of a first-level descriptor
`define DOMAIN_W 4

// TLB entry count, 2 or more
`define TLB_ENTRIES 4
// Data flag + domain + status
`define FSR_W 9
`endif

// ==== rtl/tableWalker.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mmu_params.svh"

module tableWalker
  import mmuWalkPkg::*;
  import mmuFaultPkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                requestPA,
  input  logic                dataAccess,
  input  logic                mmuEnable,
  input  logic                tlbHit,
  input  logic                memReady,
  input  logic [`DATA_W-1:0]  memRData,
  output logic                memRequest,
  output logic                tlbWrite,
  output logic                fsrWrite,
  output logic                farWrite,
  output logic                paReady,
  output logic                abort,
  output faultStatus          faultCode,
  output walkState            state
);

  walkState       nextState;
  firstLevelKind  flKind;
  secondLevelKind slKind;
  faultStatus     levelCode;
  logic           served;
  logic           fetchState;

  // Kind of the descriptor on the read bus
  assign flKind = firstLevelKind'(memRData[1:0]);
  assign slKind = secondLevelKind'(memRData[1:0]);

  // States that own the memory port
  assign fetchState = (state == FLD) || (state == COARSEFETCH) || (state == FINEFETCH);

  // ====================
  // State register
  // ====================
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= READY;
    end else if (!mmuEnable) begin
      // Disabling the MMU abandons any walk
      state <= READY;
    end else begin
      state <= nextState;
    end
  end

  // Next state
  always_comb begin
    nextState = state;
    case (state)
      READY: begin
        // Walk only for a fresh request that misses
        if (requestPA && !tlbHit && !served) begin
          nextState = FLD;
        end
      end
      FLD: begin
        if (memReady) begin
          case (flKind)
            FLFAULT:   nextState = FAULTFSR;
            FLCOARSE:  nextState = COARSEFETCH;
            FLSECTION: nextState = READY;
            default:   nextState = FINEFETCH;
          endcase
        end
      end
      COARSEFETCH: begin
        if (memReady) begin
          nextState = (slKind == SLFAULT) ? FAULTFSR : COARSED;
        end
      end
      FINEFETCH: begin
        if (memReady) begin
          nextState = (slKind == SLFAULT) ? FAULTFSR : FINED;
        end
      end
      // Fill cycle after a page descriptor
      COARSED:  nextState = READY;
      FINED:    nextState = READY;
      FAULTFSR: nextState = FAULTFAR;
      FAULTFAR: nextState = READY;
      default:  nextState = READY;
    endcase
  end

  // ====================
  // Request bookkeeping
  // ====================
  // One answer per request, cleared when requestPA drops
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      served <= 1'b0;
    end else if (!requestPA) begin
      served <= 1'b0;
    end else if (paReady || abort) begin
      served <= 1'b1;
    end
  end

  // Fault level follows the last fetch state
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      levelCode <= NOFAULT;
    end else if (state == FLD) begin
      levelCode <= SECTIONXLATE;
    end else if ((state == COARSEFETCH) || (state == FINEFETCH)) begin
      levelCode <= PAGEXLATE;
    end
  end

  // ====================
  // Outputs
  // ====================
  assign memRequest = fetchState;

  // Section fills straight off the bus, pages one cycle later
  assign tlbWrite = ((state == FLD) && memReady && (flKind == FLSECTION)) ||
                    (state == COARSED) || (state == FINED);

  // Hit or pass-through answers in the same cycle
  assign paReady = (state == READY) && requestPA && !served && (tlbHit || !mmuEnable);

  assign fsrWrite  = (state == FAULTFSR);
  assign farWrite  = (state == FAULTFAR);
  assign abort     = (state == FAULTFAR);
  assign faultCode = (state == FAULTFSR) ? levelCode : NOFAULT;

  // Requester never sees both strobes
  assert property (@(posedge clk) disable iff (reset) !(paReady && abort));

  // Memory is read only for a pending request
  assert property (@(posedge clk) disable iff (reset) memRequest |-> requestPA);

  // Walker waits on memory
  assert property (@(posedge clk) disable iff (reset)
    (fetchState && !memReady && mmuEnable) |=> $stable(state));

endmodule

`default_nettype wire

// ==== rtl/tlbArray.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mmu_params.svh"

module tlbArray
  import mmuWalkPkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 enable,
  input  logic [`VADDR_W-1:0]  lookupVirt,
  output logic                 hit,
  output logic [`PADDR_W-1:0]  hitPhys,
  input  logic                 write,
  input  logic [`VADDR_W-1:0]  fillVirt,
  input  logic [`PADDR_W-1:0]  fillPhys,
  input  pageSize              fillSize
);

  localparam int PTR_W = $clog2(`TLB_ENTRIES);

  logic [`TLB_ENTRIES-1:0] entryValid;
  logic [`VADDR_W-1:0]     entryVirt [`TLB_ENTRIES];
  logic [`PADDR_W-1:0]     entryPhys [`TLB_ENTRIES];
  pageSize                 entrySize [`TLB_ENTRIES];
  logic [`TLB_ENTRIES-1:0] hitVec;
  logic [PTR_W-1:0]        victim;
  logic [`PADDR_W-1:0]     transPhys;

  // Offset bits kept from the virtual address
  function automatic logic [`VADDR_W-1:0] offsetMask(input pageSize size);
    int unsigned bits;
    case (size)
      SECTION: bits = 20;
      LARGE:   bits = 16;
      SMALL:   bits = 12;
      default: bits = 10;
    endcase
    offsetMask = ~({`VADDR_W{1'b1}} << bits);
  endfunction

  // ====================
  // Lookup
  // ====================
  always_comb begin
    transPhys = lookupVirt;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      // Tags are stored page aligned
      hitVec[i] = entryValid[i] &&
                  ((lookupVirt & ~offsetMask(entrySize[i])) == entryVirt[i]);
      if (hitVec[i]) begin
        transPhys = entryPhys[i] | (lookupVirt & offsetMask(entrySize[i]));
      end
    end
  end

  assign hit = |hitVec;

  // Disabled MMU passes addresses through
  assign hitPhys = enable ? transPhys : lookupVirt;

  // ====================
  // Fill and flush
  // ====================
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      entryValid <= '0;
      victim     <= '0;
    end else begin
      if (flush) begin
        entryValid <= '0;
      end else if (write) begin
        entryValid[victim] <= 1'b1;
      end
      // Round robin victim
      if (write) begin
        victim <= (victim == PTR_W'(`TLB_ENTRIES - 1)) ? '0 : victim + 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (write) begin
      entryVirt[victim] <= fillVirt;
      entryPhys[victim] <= fillPhys;
      entrySize[victim] <= fillSize;
    end
  end

  // Fills only follow misses, so no overlap
  assert property (@(posedge clk) disable iff (reset) $onehot0(hitVec));

endmodule

`default_nettype wire

// ==== rtl/walkAddrGen.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mmu_params.svh"

module walkAddrGen
  import mmuWalkPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  walkState              state,
  input  logic                  memReady,
  input  logic [`DATA_W-1:0]    memRData,
  input  logic [`VADDR_W-1:0]   virtAdr,
  input  logic [`TBASE_W-1:0]   tBase,
  output logic [`PADDR_W-1:0]   memAddr,
  output logic [`VADDR_W-1:0]   fillVirt,
  output logic [`PADDR_W-1:0]   fillPhys,
  output pageSize               fillSize,
  output logic [`DOMAIN_W-1:0]  faultDomain
);

  logic [`DATA_W-1:0]   descReg;
  logic [`DOMAIN_W-1:0] domainReg;
  logic [`DATA_W-1:0]   finalDesc;
  secondLevelKind       slKind;
  logic                 descAccept;

  // Descriptor accepted at the end of a ready fetch cycle
  assign descAccept = memReady &&
                      ((state == FLD) || (state == COARSEFETCH) || (state == FINEFETCH));

  // ====================
  // Descriptor capture
  // ====================
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      descReg   <= '0;
      domainReg <= '0;
    end else if (descAccept) begin
      descReg <= memRData;
      // Domain lives in first-level bits 8:5
      if (state == FLD) begin
        domainReg <= memRData[8:5];
      end
    end
  end

  assign faultDomain = domainReg;

  // ====================
  // Fetch address
  // ====================
  always_comb begin
    case (state)
      // Coarse table index from bits 19:12
      COARSEFETCH: memAddr = {descReg[31:10], virtAdr[19:12], 2'b00};
      // Fine table index from bits 19:10
      FINEFETCH:   memAddr = {descReg[31:12], virtAdr[19:10], 2'b00};
      // First-level index, also idle value
      default:     memAddr = {tBase, virtAdr[31:20], 2'b00};
    endcase
  end

  // ====================
  // TLB fill fields
  // ====================
  // Section comes from the bus, page from the register
  assign finalDesc = (state == FLD) ? memRData : descReg;
  assign slKind    = secondLevelKind'(finalDesc[1:0]);

  always_comb begin
    if (state == FLD) begin
      fillSize = SECTION;
      fillPhys = {finalDesc[31:20], 20'b0};
      fillVirt = {virtAdr[31:20], 20'b0};
    end else begin
      case (slKind)
        SLLARGE: begin
          fillSize = LARGE;
          fillPhys = {finalDesc[31:16], 16'b0};
          fillVirt = {virtAdr[31:16], 16'b0};
        end
        SLTINY: begin
          fillSize = TINY;
          fillPhys = {finalDesc[31:10], 10'b0};
          fillVirt = {virtAdr[31:10], 10'b0};
        end
        default: begin
          fillSize = SMALL;
          fillPhys = {finalDesc[31:12], 12'b0};
          fillVirt = {virtAdr[31:12], 12'b0};
        end
      endcase
    end
  end

endmodule

`default_nettype wire
